// File: board_ctrl_regs.sv
////////////////////
// Board control registers
// Clock gen, SERDES, ADC, PHY and diversity switch controls,
// plus the per-bit hardware/software LED mux
////////////////////

module board_ctrl_regs
   import settings_pkg::*;
#(
   parameter set_addr_t MISC_BASE  = SR_MISC,
   parameter set_addr_t DIVSW_BASE = SR_DIVSW
) (
   input  logic      dsp_clk,
   input  logic      por_rst,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   input  logic      tx_run_i,
   input  logic      rx_run_i,
   input  logic      clk_status_i,
   input  logic      serdes_link_i,
   input  logic      good_sync_i,
   output logic      clock_ready_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic [3:0] ser_ctrl_o,
   output logic [3:0] adc_ctrl_o,
   output logic      phy_reset_n_o,
   output logic [1:0] div_sw_o,
   output led_t      leds_o
);

   logic [4:0] clock_outs;
   logic       phy_reset;
   led_t       led_sw;
   led_t       led_src;
   led_t       led_hw;

   ////////////////////
   // Control registers

   setting_reg #(.ADDR(set_addr_t'(MISC_BASE + MISC_CLK)), .WIDTH(5)) sr_clk (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(clock_outs), .changed_o());

   setting_reg #(.ADDR(set_addr_t'(MISC_BASE + MISC_SER)), .WIDTH(4)) sr_ser (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(ser_ctrl_o), .changed_o());

   setting_reg #(.ADDR(set_addr_t'(MISC_BASE + MISC_ADC)), .WIDTH(4)) sr_adc (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(adc_ctrl_o), .changed_o());

   setting_reg #(.ADDR(set_addr_t'(MISC_BASE + MISC_PHY)), .WIDTH(1)) sr_phy (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(phy_reset), .changed_o());

   // Both switches come up in the default antenna path
   setting_reg #(.ADDR(set_addr_t'(DIVSW_BASE + DIVSW_1)), .WIDTH(1), .AT_RESET(1'b1))
   sr_divsw1 (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(div_sw_o[0]), .changed_o());

   setting_reg #(.ADDR(set_addr_t'(DIVSW_BASE + DIVSW_2)), .WIDTH(1), .AT_RESET(1'b1))
   sr_divsw2 (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(div_sw_o[1]), .changed_o());

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_outs;
   assign phy_reset_n_o = ~phy_reset;   // PHY reset pin is active low

   ////////////////////
   // LEDs

   setting_reg #(.ADDR(set_addr_t'(MISC_BASE + MISC_LED_SW)), .WIDTH(8)) sr_led_sw (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(led_sw), .changed_o());

   setting_reg #(.ADDR(set_addr_t'(MISC_BASE + MISC_LED_SRC)), .WIDTH(8),
                 .AT_RESET(LED_SRC_RESET)) sr_led_src (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(led_src), .changed_o());

   assign led_hw = {3'b000, tx_run_i, rx_run_i, clk_status_i,
                    serdes_link_i & good_sync_i, 1'b0};

   // Source bit 1 picks hardware, 0 picks software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   // Switch controls must be defined from the first cycle out of reset
   assert property (@(posedge dsp_clk) disable iff (por_rst) !$isunknown(div_sw_o))
      else $error("diversity switch output unknown");

endmodule

// File: radio_core.sv
////////////////////
// Radio core slow control
// Settings registers, board controls, VITA time
// and status readback in the DSP clock domain
////////////////////

module radio_core
   import settings_pkg::*;
   import timing_pkg::*;
#(
   parameter set_addr_t MISC_BASE  = SR_MISC,
   parameter set_addr_t TIME_BASE  = SR_TIME64,
   parameter set_addr_t DIVSW_BASE = SR_DIVSW,
   parameter rb_data_t  COMPAT     = COMPAT_NUM
) (
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       rd_stb_i,
   input  rb_addr_t   rd_addr_i,
   output rb_data_t   rd_data_o,
   output logic       rd_ack_o,
   input  logic       pps_i,
   input  logic       tx_run_i,
   input  logic       rx_run_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_i,
   output logic       clock_ready_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   output logic [3:0] ser_ctrl_o,
   output logic [3:0] adc_ctrl_o,
   output logic       phy_reset_n_o,
   output logic [1:0] div_sw_o,
   output led_t       leds_o,
   output logic       pps_int_o
);

   vita_time_t load_time;
   logic       load_now;
   logic       load_pps;
   logic       pps_seen;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   logic       good_sync;

   board_ctrl_regs #(.MISC_BASE(MISC_BASE), .DIVSW_BASE(DIVSW_BASE)) i_board_ctrl_regs (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .tx_run_i, .rx_run_i, .clk_status_i, .serdes_link_i,
      .good_sync_i(good_sync),
      .clock_ready_o, .clk_en_o, .clk_sel_o, .ser_ctrl_o, .adc_ctrl_o,
      .phy_reset_n_o, .div_sw_o, .leds_o);

   ////////////////////
   // VITA time

   vita_time_regs #(.TIME_BASE(TIME_BASE)) i_vita_time_regs (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .pps_seen_i(pps_seen),
      .load_time_o(load_time), .load_now_o(load_now), .load_pps_o(load_pps));

   vita_time_counter i_vita_time_counter (
      .dsp_clk, .por_rst, .pps_i,
      .load_time_i(load_time), .load_now_i(load_now), .load_pps_i(load_pps),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps),
      .pps_int_o, .pps_seen_o(pps_seen), .good_sync_o(good_sync));

   ////////////////////
   // Software readback

   status_readback #(.COMPAT(COMPAT)) i_status_readback (
      .dsp_clk, .por_rst, .rd_stb_i, .rd_addr_i,
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .good_sync_i(good_sync), .clk_status_i, .serdes_link_i,
      .rd_data_o, .rd_ack_o);

endmodule

// File: radio_core_tb.sv
////////////////////
// Radio core testbench
// Self-checking run over reset values, control registers,
// LED mux, immediate time load and PPS load and capture
////////////////////

module radio_core_tb;
   import settings_pkg::*;
   import timing_pkg::*;

   localparam int RD_TIMEOUT  = 8;    // Cycles to wait for rd_ack_o
   localparam int PPS_TIMEOUT = 24;   // Cycles to wait for a detected PPS edge

   logic       dsp_clk;
   logic       por_rst;
   logic       set_stb_i;
   set_addr_t  set_addr_i;
   set_data_t  set_data_i;
   logic       rd_stb_i;
   rb_addr_t   rd_addr_i;
   rb_data_t   rd_data_o;
   logic       rd_ack_o;
   logic       pps_i;
   logic       tx_run_i;
   logic       rx_run_i;
   logic       clk_status_i;
   logic       serdes_link_i;
   logic       clock_ready_o;
   logic [1:0] clk_en_o;
   logic [1:0] clk_sel_o;
   logic [3:0] ser_ctrl_o;
   logic [3:0] adc_ctrl_o;
   logic       phy_reset_n_o;
   logic [1:0] div_sw_o;
   led_t       leds_o;
   logic       pps_int_o;

   logic [31:0] rng;
   int          error_count;
   int          check_count;
   int          test_count;
   int          errors_before;
   int          cycle_cnt;
   int          pps_pulses;
   string       test_name;
   logic        led_check_en;
   led_t        exp_src;            // LED model
   led_t        exp_sw;

   radio_core i_radio_core (.*);

   always #2 dsp_clk = ~dsp_clk;

   ////////////////////
   // Helpers

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   // Expected LEDs, hardware bit where the source bit is set
   function automatic led_t led_ref(input led_t src, input led_t sw, input logic tx,
                                    input logic rx, input logic clk_st, input logic link,
                                    input logic sync);
      led_t hw;
      led_t res;
      hw    = '0;
      hw[4] = tx;
      hw[3] = rx;
      hw[2] = clk_st;
      hw[1] = link & sync;
      for (int b = 0; b < 8; b++) begin
         res[b] = src[b] ? hw[b] : sw[b];
      end
      return res;
   endfunction

   // Addresses outside every register block
   function automatic set_addr_t unmapped_addr(input logic [2:0] idx);
      case (idx)
         3'd0:    return 8'd5;
         3'd1:    return 8'd7;
         3'd2:    return 8'd8;
         3'd3:    return 8'd9;
         3'd4:    return 8'd13;
         3'd5:    return 8'd100;
         3'd6:    return 8'd179;
         default: return 8'd182;
      endcase
   endfunction

   task automatic verify_leds(input string name, input led_t exp, input led_t act);
      check_count++;
      if (exp !== act) begin
         error_count++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic compare_word(input string name, input rb_data_t exp, input rb_data_t act);
      check_count++;
      if (exp !== act) begin
         error_count++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic expect_time(input string name, input vita_time_t exp, input vita_time_t act);
      check_count++;
      if (exp !== act) begin
         error_count++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic ctrl_check(input string name, input set_data_t exp, input set_data_t act);
      check_count++;
      if (exp !== act) begin
         error_count++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      @(negedge dsp_clk);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      @(negedge dsp_clk);
      set_stb_i  = 1'b0;   // Register holds the new value from here
   endtask

   task automatic read_word(input rb_addr_t addr, output rb_data_t data);
      int waited;
      @(negedge dsp_clk);
      rd_stb_i  = 1'b1;
      rd_addr_i = addr;
      @(negedge dsp_clk);
      rd_stb_i = 1'b0;
      waited   = 0;
      while (!rd_ack_o && waited < RD_TIMEOUT) begin
         @(negedge dsp_clk);
         waited++;
      end
      if (!rd_ack_o) begin
         error_count++;
         $display("%s: no readback acknowledge for word %0d", test_name, addr);
      end
      data = rd_data_o;
   endtask

   task automatic wait_pps_count(input int count);
      int waited;
      waited = 0;
      while (pps_pulses < count && waited < PPS_TIMEOUT) begin
         @(negedge dsp_clk);
         waited++;
      end
      if (pps_pulses < count) begin
         error_count++;
         $display("%s: PPS edge %0d was never detected", test_name, count);
      end
   endtask

   task automatic finish_test();
      test_count++;
      if (error_count == errors_before) begin
         $display("test %s: passed", test_name);
      end else begin
         $display("test %s: FAILED with %0d errors", test_name, error_count - errors_before);
      end
      errors_before = error_count;
   endtask

   ////////////////////
   // Compare process and counters

   always @(posedge dsp_clk) begin
      if (led_check_en) begin
         // No PPS has arrived while LED checks run
         verify_leds(test_name, led_ref(exp_src, exp_sw, tx_run_i, rx_run_i, clk_status_i,
                                         serdes_link_i, 1'b0), leds_o);
      end
   end

   always @(posedge dsp_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (por_rst) begin
         pps_pulses <= 0;
      end else if (pps_int_o) begin
         pps_pulses <= pps_pulses + 1;
      end
   end

   ////////////////////
   // Stimulus

   initial begin
      logic [31:0] r;
      set_data_t   data;
      set_addr_t   addr;
      rb_data_t    rd_hi;
      rb_data_t    rd_lo;
      vita_time_t  t_load;
      logic [4:0]  exp_clk;
      logic [3:0]  exp_ser;
      logic [3:0]  exp_adc;
      logic        exp_phy;
      logic [1:0]  exp_div;
      int          m;
      int          rise_cycle;
      int          waited;

      dsp_clk       = 1'b0;
      por_rst       = 1'b1;
      set_stb_i     = 1'b0;
      set_addr_i    = '0;
      set_data_i    = '0;
      rd_stb_i      = 1'b0;
      rd_addr_i     = '0;
      pps_i         = 1'b0;
      tx_run_i      = 1'b0;
      rx_run_i      = 1'b0;
      clk_status_i  = 1'b0;
      serdes_link_i = 1'b0;
      rng           = 32'hb12e_9ebf;
      error_count   = 0;
      check_count   = 0;
      test_count    = 0;
      errors_before = 0;
      cycle_cnt     = 0;
      led_check_en  = 1'b0;
      exp_src       = 8'b0001_1110;
      exp_sw        = 8'h00;
      exp_clk       = '0;
      exp_ser       = '0;
      exp_adc       = '0;
      exp_phy       = 1'b0;
      exp_div       = 2'b11;

      repeat (3) @(negedge dsp_clk);
      por_rst = 1'b0;

      // 1. Reset values
      test_name    = "reset_values";
      led_check_en = 1'b1;
      repeat (4) @(negedge dsp_clk);
      ctrl_check(test_name, {16'd0, 2'b11, 1'b1, 13'd0},
                 {16'd0, div_sw_o, phy_reset_n_o, adc_ctrl_o, ser_ctrl_o,
                  clock_ready_o, clk_en_o, clk_sel_o});
      read_word(4'd0, rd_hi);
      compare_word(test_name, {16'd8, 16'd2}, rd_hi);
      clk_status_i  = 1'b1;
      serdes_link_i = 1'b1;
      read_word(4'd5, rd_hi);
      compare_word(test_name, 32'h0000_0003, rd_hi);   // Sync low, clock and link up
      finish_test();

      // 2. Control registers, with writes to unmapped addresses mixed in
      test_name = "control_regs";
      for (int i = 0; i < 32; i++) begin
         r    = next_rand();
         data = next_rand();
         case (r[2:0])
            3'd0: begin addr = 8'd0;   exp_clk    = data[4:0]; end
            3'd1: begin addr = 8'd1;   exp_ser    = data[3:0]; end
            3'd2: begin addr = 8'd2;   exp_adc    = data[3:0]; end
            3'd3: begin addr = 8'd4;   exp_phy    = data[0];   end
            3'd4: begin addr = 8'd180; exp_div[0] = data[0];   end
            3'd5: begin addr = 8'd181; exp_div[1] = data[0];   end
            default: addr = unmapped_addr(r[10:8]);
         endcase
         write_setting(addr, data);
         ctrl_check(test_name, {16'd0, exp_div, ~exp_phy, exp_adc, exp_ser, exp_clk},
                    {16'd0, div_sw_o, phy_reset_n_o, adc_ctrl_o, ser_ctrl_o,
                     clock_ready_o, clk_en_o, clk_sel_o});
      end
      finish_test();

      // 3. LED mux
      test_name = "led_mux";
      for (int i = 0; i < 16; i++) begin
         data = next_rand();
         write_setting(8'd6, data);
         exp_src = data[7:0];
         data    = next_rand();
         write_setting(8'd3, data);
         exp_sw  = data[7:0];
         r = next_rand();
         tx_run_i      = r[0];
         rx_run_i      = r[1];
         clk_status_i  = r[2];
         serdes_link_i = r[3];
         repeat (3) @(negedge dsp_clk);
      end
      led_check_en = 1'b0;
      finish_test();

      // 4. Immediate load
      test_name = "immediate_load";
      data = next_rand();
      write_setting(8'd10, data);
      write_setting(8'd11, 32'd0);
      write_setting(8'd12, 32'd0);
      read_word(4'd1, rd_hi);
      compare_word(test_name, data, rd_hi);
      finish_test();

      // 5. PPS load and capture
      test_name     = "pps_load";
      clk_status_i  = 1'b1;
      serdes_link_i = 1'b0;
      t_load        = {next_rand(), next_rand()};
      r             = next_rand();
      m             = 40 + int'(r[4:0]);
      write_setting(8'd10, t_load[63:32]);
      write_setting(8'd11, t_load[31:0]);
      write_setting(8'd12, 32'd1);          // Load at next PPS
      @(negedge dsp_clk);
      pps_i      = 1'b1;
      rise_cycle = cycle_cnt;
      repeat (5) @(negedge dsp_clk);
      pps_i = 1'b0;
      wait_pps_count(1);
      read_word(4'd3, rd_hi);
      read_word(4'd4, rd_lo);
      expect_time(test_name, t_load, {rd_hi, rd_lo});
      waited = 0;
      while (cycle_cnt < rise_cycle + m && waited < 100) begin
         @(negedge dsp_clk);
         waited++;
      end
      if (cycle_cnt != rise_cycle + m) begin
         error_count++;
         $display("%s: second PPS pulse could not be placed %0d cycles after the first",
                  test_name, m);
      end
      pps_i = 1'b1;
      repeat (5) @(negedge dsp_clk);
      pps_i = 1'b0;
      wait_pps_count(2);
      read_word(4'd3, rd_hi);
      read_word(4'd4, rd_lo);
      expect_time(test_name, t_load + vita_time_t'(m), {rd_hi, rd_lo});
      read_word(4'd5, rd_hi);
      compare_word(test_name, 32'h0000_0006, rd_hi);   // Sync and clock status set
      repeat (10) @(negedge dsp_clk);
      compare_word(test_name, 32'd2, rb_data_t'(pps_pulses));
      finish_test();

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: setting_reg.sv
////////////////////
// Settings register
// Holds the low WIDTH bits of the last write to ADDR
// and pulses changed_o for one cycle after each write
////////////////////

module setting_reg
   import settings_pkg::*;
#(
   parameter set_addr_t        ADDR     = '0,
   parameter int               WIDTH    = 32,
   parameter logic [WIDTH-1:0] AT_RESET = '0
) (
   input  logic             dsp_clk,
   input  logic             por_rst,
   input  logic             set_stb_i,
   input  set_addr_t        set_addr_i,
   input  set_data_t        set_data_i,
   output logic [WIDTH-1:0] out_o,
   output logic             changed_o
);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == ADDR);   // Address decode

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         out_o     <= AT_RESET;
         changed_o <= 1'b0;
      end else begin
         changed_o <= hit;
         if (hit) begin
            out_o <= set_data_i[WIDTH-1:0];
         end
      end
   end

endmodule

// File: settings_pkg.sv
////////////////////
// Settings bus package
// Write port word types and the register address map
////////////////////

package settings_pkg;

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [7:0]  led_t;

   ////////////////////
   // Register block bases

   localparam set_addr_t SR_MISC   = 8'd0;
   localparam set_addr_t SR_TIME64 = 8'd10;
   localparam set_addr_t SR_DIVSW  = 8'd180;

   // Misc block offsets
   localparam int MISC_CLK     = 0;   // 5-bit clock gen control
   localparam int MISC_SER     = 1;   // SERDES enables
   localparam int MISC_ADC     = 2;
   localparam int MISC_LED_SW  = 3;   // Software LED value
   localparam int MISC_PHY     = 4;
   localparam int MISC_LED_SRC = 6;   // Per-bit LED source select

   // Time block offsets
   localparam int TIME_HI  = 0;
   localparam int TIME_LO  = 1;
   localparam int TIME_CMD = 2;       // Bit 0 set means load at next PPS

   // Diversity switch offsets
   localparam int DIVSW_1 = 0;
   localparam int DIVSW_2 = 1;

   // Hardware owns run and status LEDs out of reset
   localparam led_t LED_SRC_RESET = 8'b0001_1110;

endpackage

// File: status_readback.sv
////////////////////
// Status readback
// Registered word mux for software reads, ack one cycle
// after the strobe
////////////////////

module status_readback
   import timing_pkg::*;
#(
   parameter rb_data_t COMPAT = COMPAT_NUM
) (
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       rd_stb_i,
   input  rb_addr_t   rd_addr_i,
   input  vita_time_t vita_time_i,
   input  vita_time_t vita_time_pps_i,
   input  logic       good_sync_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_i,
   output rb_data_t   rd_data_o,
   output logic       rd_ack_o
);

   rb_data_t rd_word;

   always_comb begin
      case (rd_addr_i)
         RB_COMPAT:  rd_word = COMPAT;
         RB_TIME_HI: rd_word = vita_time_i[63:32];
         RB_TIME_LO: rd_word = vita_time_i[31:0];
         RB_PPS_HI:  rd_word = vita_time_pps_i[63:32];
         RB_PPS_LO:  rd_word = vita_time_pps_i[31:0];
         RB_BOARD:   rd_word = {29'd0, good_sync_i, clk_status_i, serdes_link_i};
         default:    rd_word = '0;   // Unmapped words
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (rd_stb_i) begin
         rd_data_o <= rd_word;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rd_ack_o <= 1'b0;
      end else begin
         rd_ack_o <= rd_stb_i;
      end
   end

   assert property (@(posedge dsp_clk) disable iff (por_rst) rd_ack_o |-> $past(rd_stb_i))
      else $error("readback ack without a strobe");

endmodule

// File: timing_pkg.sv
////////////////////
// Timing package
// VITA time and readback types, readback word map
////////////////////

package timing_pkg;

   typedef logic [63:0] vita_time_t;
   typedef logic [3:0]  rb_addr_t;
   typedef logic [31:0] rb_data_t;

   // Bumped whenever the register map changes
   localparam rb_data_t COMPAT_NUM = {16'd8, 16'd2};   // Major in the upper half

   ////////////////////
   // Readback word indices

   localparam rb_addr_t RB_COMPAT  = 4'd0;
   localparam rb_addr_t RB_TIME_HI = 4'd1;
   localparam rb_addr_t RB_TIME_LO = 4'd2;
   localparam rb_addr_t RB_PPS_HI  = 4'd3;
   localparam rb_addr_t RB_PPS_LO  = 4'd4;
   localparam rb_addr_t RB_BOARD   = 4'd5;   // Sync and link status

endpackage

// File: verilog.f
settings_pkg.sv
timing_pkg.sv
setting_reg.sv
board_ctrl_regs.sv
vita_time_regs.sv
vita_time_counter.sv
status_readback.sv
radio_core.sv
radio_core_tb.sv

// File: vita_time_counter.sv
////////////////////
// VITA time counter
// 64-bit time base with immediate and PPS-aligned loads,
// PPS synchronizer, capture of the time at each PPS edge
////////////////////

module vita_time_counter
   import timing_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       pps_i,
   input  vita_time_t load_time_i,
   input  logic       load_now_i,
   input  logic       load_pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       pps_int_o,
   output logic       pps_seen_o,
   output logic       good_sync_o
);

   logic [2:0] pps_sync;     // Two sync stages and the previous sample
   logic       pps_edge;
   vita_time_t time_next;

   assign pps_edge = pps_sync[1] & ~pps_sync[2];

   always_comb begin
      if (load_now_i) begin
         time_next = load_time_i;
      end else if (pps_edge && load_pps_i) begin
         time_next = load_time_i;          // Armed load lands on the edge
      end else begin
         time_next = vita_time_o + 64'd1;
      end
   end

   ////////////////////
   // Time and sync state

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_sync    <= '0;
         vita_time_o <= '0;
         good_sync_o <= 1'b0;
      end else begin
         pps_sync    <= {pps_sync[1:0], pps_i};
         vita_time_o <= time_next;
         if (pps_edge) begin
            good_sync_o <= 1'b1;           // Sticky until reset
         end
      end
   end

   // Captures the value the counter takes at the edge
   always_ff @(posedge dsp_clk) begin
      if (pps_edge) begin
         vita_time_pps_o <= time_next;
      end
   end

   assign pps_int_o  = pps_edge;
   assign pps_seen_o = pps_edge;   // Clears the pending load upstream

   assert property (@(posedge dsp_clk) disable iff (por_rst) pps_int_o |=> !pps_int_o)
      else $error("PPS pulse longer than one cycle");

endmodule

// File: vita_time_regs.sv
////////////////////
// VITA time load registers
// Holds the load value and turns command writes into
// an immediate load strobe or a pending PPS load
////////////////////

module vita_time_regs
   import settings_pkg::*;
   import timing_pkg::*;
#(
   parameter set_addr_t TIME_BASE = SR_TIME64
) (
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       pps_seen_i,
   output vita_time_t load_time_o,
   output logic       load_now_o,
   output logic       load_pps_o
);

   logic [31:0] time_hi;
   logic [31:0] time_lo;
   logic        cmd_pps;
   logic        cmd_changed;
   logic        pps_pending;

   setting_reg #(.ADDR(set_addr_t'(TIME_BASE + TIME_HI)), .WIDTH(32)) sr_time_hi (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(time_hi), .changed_o());

   setting_reg #(.ADDR(set_addr_t'(TIME_BASE + TIME_LO)), .WIDTH(32)) sr_time_lo (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(time_lo), .changed_o());

   // Writing the command kicks off the load
   setting_reg #(.ADDR(set_addr_t'(TIME_BASE + TIME_CMD)), .WIDTH(1)) sr_time_cmd (
      .dsp_clk, .por_rst, .set_stb_i, .set_addr_i, .set_data_i,
      .out_o(cmd_pps), .changed_o(cmd_changed));

   assign load_time_o = {time_hi, time_lo};
   assign load_now_o  = cmd_changed & ~cmd_pps;
   assign load_pps_o  = pps_pending;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_pending <= 1'b0;
      end else if (cmd_changed) begin
         pps_pending <= cmd_pps;         // Latest command wins
      end else if (pps_seen_i) begin
         pps_pending <= 1'b0;            // Consumed by the counter
      end
   end

   // Immediate load never lands together with a freshly armed PPS load
   assert property (@(posedge dsp_clk) disable iff (por_rst)
                    !(load_now_o && $rose(load_pps_o)))
      else $error("immediate load while a PPS load was just armed");

endmodule
